// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = nand_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
design/nand_pkg.sv
design/nand_addr_latch.sv
design/nand_cmd_fsm.sv
design/nand_page_buffer.sv
design/nand_array_seq.sv
design/nand_flash_top.sv
dv/nand_flash_chk.sv
dv/nand_monitor.sv
dv/nand_tb.sv

// File: design/nand_addr_latch.sv
// NAND address latch, counts address cycles and holds column and row with column auto-increment
`default_nettype none

module nand_addr_latch (
    input  logic                RE_B,
    input  logic                CE_B,
    input  logic                ale,
    input  logic                we,
    input  logic                row_only,
    input  logic                col_step,
    input  nand_pkg::io_byte_t  din,
    output nand_pkg::col_addr_t col,
    output nand_pkg::row_addr_t row
);
    import nand_pkg::*;

    logic [1:0] cyc;        // Expected cycle of next address byte
    logic       in_phase;   // Last strobe was an address byte
    logic       row_mode;   // Erase setup seen, phase begins at row low
    logic [1:0] idx;        // Cycle this strobe fills
    logic       addr_we;

    assign addr_we = we & ale;

    // First byte of a phase picks its start, later bytes follow the count
    assign idx = in_phase ? cyc : (row_mode ? 2'd2 : 2'd0);

    always_ff @(posedge RE_B or posedge CE_B) begin
        if (CE_B) begin
            cyc      <= 2'd0;
            in_phase <= 1'b0;
            row_mode <= 1'b0;
        end else begin
            if (row_only) begin
                row_mode <= 1'b1;
            end else if (addr_we) begin
                row_mode <= 1'b0;       // Only the first byte needs it
            end
            if (addr_we) begin
                cyc      <= idx + 2'd1; // Wraps after row high
                in_phase <= 1'b1;
            end else if (we) begin
                in_phase <= 1'b0;       // Command or data ends the phase
            end
        end
    end

    // High column and high row cycles carry no bits at this geometry
    always_ff @(posedge RE_B or posedge CE_B) begin
        if (CE_B) begin
            col <= '0;
            row <= '0;
        end else if (addr_we) begin
            if (idx == 2'd0) begin
                col <= din[COL_BITS-1:0];   // Column low
            end else if (idx == 2'd2) begin
                row <= din[ROW_BITS-1:0];   // Row low, {block, page}
            end
        end else if (col_step) begin
            col <= col + 1'b1;              // Next byte, wraps in page
        end
    end

endmodule

`default_nettype wire

// File: design/nand_array_seq.sv
// NAND cell array with busy sequencer for page load, page program, block erase and reset
`default_nettype none

module nand_array_seq #(
    parameter int COL_BITS   = nand_pkg::COL_BITS,
    parameter int PAGE_BITS  = nand_pkg::PAGE_BITS,
    parameter int BLOCK_BITS = nand_pkg::BLOCK_BITS,
    parameter int T_READ     = nand_pkg::T_READ,
    parameter int T_PROG     = nand_pkg::T_PROG,
    parameter int T_ERASE    = nand_pkg::T_ERASE,
    parameter int T_RST      = nand_pkg::T_RST
) (
    input  logic                RE_B,
    input  logic                CE_B,
    input  logic                start,
    input  nand_pkg::seq_op_e   op,
    input  nand_pkg::row_addr_t row,
    input  nand_pkg::io_byte_t  seq_rdata,
    output logic                busy,
    output logic                seq_we,
    output nand_pkg::col_addr_t seq_col,
    output nand_pkg::io_byte_t  seq_wdata
);
    import nand_pkg::*;

    localparam int ROW_W  = PAGE_BITS + BLOCK_BITS;
    localparam int WALK_W = PAGE_BITS + COL_BITS;           // Enough for a whole block
    localparam int ADDR_W = ROW_W + COL_BITS;
    localparam int T_RP   = (T_READ > T_PROG) ? T_READ : T_PROG;
    localparam int T_ER   = (T_ERASE > T_RST) ? T_ERASE : T_RST;
    localparam int T_MAX  = (T_RP > T_ER) ? T_RP : T_ER;
    localparam int WAIT_W = $clog2(T_MAX + 1);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WAIT,       // Busy time before the byte walk
        SEQ_WALK        // One byte per cycle
    } seq_phase_e;

    seq_phase_e        phase;
    seq_op_e           op_q;
    row_addr_t         row_q;
    logic [WAIT_W-1:0] wait_cnt;
    logic [WAIT_W-1:0] wait_init;
    logic [WALK_W-1:0] walk;
    logic              walk_end;
    logic [ADDR_W-1:0] cell_addr;
    io_byte_t          cells [2 ** ADDR_W];

    // Count loads T-1 so the wait lasts T cycles
    always_comb begin
        case (op)
            LOAD:    wait_init = WAIT_W'(T_READ - 1);
            PROGRAM: wait_init = WAIT_W'(T_PROG - 1);
            ERASE:   wait_init = WAIT_W'(T_ERASE - 1);
            default: wait_init = WAIT_W'(T_RST - 1);
        endcase
    end

    // Erase walks every page of the block, the others one page
    assign walk_end  = (op_q == ERASE) ? (walk == '1) : (walk[COL_BITS-1:0] == '1);
    assign cell_addr = (op_q == ERASE) ? {row_q[ROW_W-1:PAGE_BITS], walk}
                                       : {row_q, walk[COL_BITS-1:0]};

    assign busy      = (phase != SEQ_IDLE);
    assign seq_col   = walk[COL_BITS-1:0];
    assign seq_wdata = cells[cell_addr];
    assign seq_we    = (phase == SEQ_WALK) && (op_q == LOAD);

    always_ff @(posedge RE_B or posedge CE_B) begin
        if (CE_B) begin
            phase    <= SEQ_IDLE;
            op_q     <= NONE;
            row_q    <= '0;
            wait_cnt <= '0;
            walk     <= '0;
        end else begin
            case (phase)
                SEQ_IDLE: begin
                    if (start && op != NONE) begin
                        phase    <= SEQ_WAIT;
                        op_q     <= op;
                        row_q    <= row;            // Held for the whole op
                        wait_cnt <= wait_init;
                        walk     <= '0;
                    end
                end
                SEQ_WAIT: begin
                    if (wait_cnt == '0) begin
                        phase <= (op_q == RESET) ? SEQ_IDLE : SEQ_WALK;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                SEQ_WALK: begin
                    if (walk_end) begin
                        phase <= SEQ_IDLE;          // Ready again
                    end else begin
                        walk <= walk + 1'b1;
                    end
                end
                default: phase <= SEQ_IDLE;
            endcase
        end
    end

    // Cells only go from 1 to 0 on program, back to FF on erase
    always_ff @(posedge RE_B) begin
        if (phase == SEQ_WALK) begin
            if (op_q == PROGRAM) begin
                cells[cell_addr] <= cells[cell_addr] & seq_rdata;
            end else if (op_q == ERASE) begin
                cells[cell_addr] <= 8'hFF;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/nand_cmd_fsm.sv
// NAND command FSM that decodes commands, starts sequencer ops and returns status, ID or page bytes
`default_nettype none

module nand_cmd_fsm (
    input  logic               RE_B,
    input  logic               CE_B,
    input  logic               cle,
    input  logic               ale,
    input  logic               we,
    input  logic               re,
    input  logic               wp_n,
    input  logic               busy,
    input  nand_pkg::io_byte_t din,
    input  nand_pkg::io_byte_t buf_rdata,
    output nand_pkg::io_byte_t dout,
    output logic               dout_valid,
    output logic               buf_we,
    output logic               buf_clear,
    output logic               col_step,
    output logic               row_only,
    output logic               start,
    output nand_pkg::seq_op_e  op
);
    import nand_pkg::*;

    nand_state_e state;
    nand_state_e state_nxt;
    logic        status_mode;   // Reads return status after 70
    logic        id_mode;       // Reads walk the ID bytes after 90
    logic [1:0]  id_idx;
    logic        ready;
    logic        cmd_we;
    logic        cmd_ok;        // Command taken into mode registers
    logic        read_ok;
    logic        buf_rd;
    io_byte_t    status_byte;

    assign ready   = ~busy;                                     // Same as ryby
    assign cmd_we  = we & cle;
    assign cmd_ok  = cmd_we & (ready | (din == CMD_STATUS));   // Only 70 while busy
    assign read_ok = re & (status_mode | ready);
    assign buf_rd  = read_ok & ~status_mode & ~id_mode;

    // Data bytes only count inside a program setup
    assign buf_we   = we & ~cle & ~ale & (state == PROG_DATA);
    assign col_step = buf_we | buf_rd;

    // Bit 7 is write protect and bits 6 and 5 show ready
    assign status_byte = {wp_n, ~busy, ~busy, 5'b0};

    always_comb begin
        state_nxt = state;
        start     = 1'b0;
        op        = NONE;
        row_only  = 1'b0;
        buf_clear = 1'b0;
        if (ready) begin
            if (state == BUSY_WAIT) begin
                state_nxt = IDLE;                   // Op done
            end
            if (cmd_we) begin
                case (din)
                    CMD_READ1:   state_nxt = READ_ADDR;
                    CMD_READ2: begin
                        if (state == READ_ADDR) begin
                            start     = 1'b1;
                            op        = LOAD;
                            state_nxt = BUSY_WAIT;
                        end else begin
                            state_nxt = IDLE;
                        end
                    end
                    CMD_STATUS: begin
                        // Setup stays open
                    end
                    CMD_READ_ID: state_nxt = IDLE;
                    CMD_PROG1: begin
                        if (wp_n) begin
                            buf_clear = 1'b1;       // Unwritten bytes stay FF
                            state_nxt = PROG_DATA;
                        end
                    end
                    CMD_PROG2: begin
                        if (state == PROG_DATA) begin
                            start     = 1'b1;
                            op        = PROGRAM;
                            state_nxt = BUSY_WAIT;
                        end else begin
                            state_nxt = IDLE;
                        end
                    end
                    CMD_ERASE1: begin
                        if (wp_n) begin
                            row_only  = 1'b1;       // Erase skips column cycles
                            state_nxt = ERASE_ADDR;
                        end
                    end
                    CMD_ERASE2: begin
                        if (state == ERASE_ADDR) begin
                            start     = 1'b1;
                            op        = ERASE;
                            state_nxt = BUSY_WAIT;
                        end else begin
                            state_nxt = IDLE;
                        end
                    end
                    CMD_RESET: begin
                        start     = 1'b1;
                        op        = RESET;
                        state_nxt = BUSY_WAIT;
                    end
                    default: state_nxt = IDLE;      // Unknown code drops setup
                endcase
            end
        end
    end

    always_ff @(posedge RE_B or posedge CE_B) begin
        if (CE_B) begin
            state       <= IDLE;
            status_mode <= 1'b0;
            id_mode     <= 1'b0;
            id_idx      <= 2'd0;
            dout_valid  <= 1'b0;
        end else begin
            state      <= state_nxt;
            dout_valid <= read_ok;          // One cycle per read strobe
            if (cmd_ok) begin
                status_mode <= (din == CMD_STATUS);
                id_mode     <= (din == CMD_READ_ID);
                id_idx      <= 2'd0;
            end else if (read_ok && id_mode) begin
                id_idx <= id_idx + 2'd1;    // Cycles through the four
            end
        end
    end

    // Output register loads only on a taken read
    always_ff @(posedge RE_B) begin
        if (read_ok) begin
            if (status_mode) begin
                dout <= status_byte;
            end else if (id_mode) begin
                dout <= ID_BYTES[id_idx];
            end else begin
                dout <= buf_rdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/nand_flash_top.sv
// NAND flash top level, joins address latch, command FSM, page buffer and array sequencer
`default_nettype none

module nand_flash_top #(
    parameter int COL_BITS   = nand_pkg::COL_BITS,
    parameter int PAGE_BITS  = nand_pkg::PAGE_BITS,
    parameter int BLOCK_BITS = nand_pkg::BLOCK_BITS,
    parameter int T_READ     = nand_pkg::T_READ,
    parameter int T_PROG     = nand_pkg::T_PROG,
    parameter int T_ERASE    = nand_pkg::T_ERASE,
    parameter int T_RST      = nand_pkg::T_RST
) (
    input  logic               RE_B,
    input  logic               CE_B,
    input  logic               cle,
    input  logic               ale,
    input  logic               we,
    input  logic               re,
    input  logic               wp_n,
    input  nand_pkg::io_byte_t din,
    output nand_pkg::io_byte_t dout,
    output logic               dout_valid,
    output logic               ryby
);
    import nand_pkg::*;

    col_addr_t col;
    col_addr_t seq_col;
    row_addr_t row;
    io_byte_t  buf_rdata;
    io_byte_t  seq_rdata;
    io_byte_t  seq_wdata;
    seq_op_e   op;
    logic      buf_we;
    logic      buf_clear;
    logic      col_step;
    logic      row_only;
    logic      start;
    logic      seq_we;
    logic      busy;

    assign ryby = ~busy;    // Ready when no op runs

    nand_addr_latch i_addr (
        .RE_B(RE_B), .CE_B(CE_B), .ale(ale), .we(we),
        .row_only(row_only), .col_step(col_step), .din(din),
        .col(col), .row(row)
    );

    nand_cmd_fsm i_fsm (
        .RE_B(RE_B), .CE_B(CE_B), .cle(cle), .ale(ale), .we(we), .re(re),
        .wp_n(wp_n), .busy(busy), .din(din), .buf_rdata(buf_rdata),
        .dout(dout), .dout_valid(dout_valid), .buf_we(buf_we),
        .buf_clear(buf_clear), .col_step(col_step), .row_only(row_only),
        .start(start), .op(op)
    );

    nand_page_buffer #(.COL_BITS(COL_BITS)) i_buf (
        .RE_B(RE_B), .CE_B(CE_B), .buf_we(buf_we), .clear(buf_clear),
        .seq_we(seq_we), .col(col), .seq_col(seq_col), .wdata(din),
        .seq_wdata(seq_wdata), .rdata(buf_rdata), .seq_rdata(seq_rdata)
    );

    nand_array_seq #(
        .COL_BITS(COL_BITS), .PAGE_BITS(PAGE_BITS), .BLOCK_BITS(BLOCK_BITS),
        .T_READ(T_READ), .T_PROG(T_PROG), .T_ERASE(T_ERASE), .T_RST(T_RST)
    ) i_seq (
        .RE_B(RE_B), .CE_B(CE_B), .start(start), .op(op), .row(row),
        .seq_rdata(seq_rdata), .busy(busy), .seq_we(seq_we),
        .seq_col(seq_col), .seq_wdata(seq_wdata)
    );

endmodule

`default_nettype wire

// File: design/nand_page_buffer.sv
// NAND page buffer, one page of bytes with a host port and a sequencer port
`default_nettype none

module nand_page_buffer #(
    parameter int COL_BITS = nand_pkg::COL_BITS
) (
    input  logic                RE_B,
    input  logic                CE_B,
    input  logic                buf_we,
    input  logic                clear,
    input  logic                seq_we,
    input  nand_pkg::col_addr_t col,
    input  nand_pkg::col_addr_t seq_col,
    input  nand_pkg::io_byte_t  wdata,
    input  nand_pkg::io_byte_t  seq_wdata,
    output nand_pkg::io_byte_t  rdata,
    output nand_pkg::io_byte_t  seq_rdata
);
    import nand_pkg::*;

    localparam int PAGE_LEN = 2 ** COL_BITS;

    io_byte_t page [PAGE_LEN];

    // Clear wins, sequencer and host never write together
    always_ff @(posedge RE_B or posedge CE_B) begin
        if (CE_B) begin
            for (int i = 0; i < PAGE_LEN; i++) begin
                page[i] <= 8'hFF;       // Blank page
            end
        end else if (clear) begin
            for (int i = 0; i < PAGE_LEN; i++) begin
                page[i] <= 8'hFF;       // Program setup, whole page in one cycle
            end
        end else if (seq_we) begin
            page[seq_col] <= seq_wdata; // Page load from array
        end else if (buf_we) begin
            page[col] <= wdata;         // Host data byte
        end
    end

    // Both reads combinational
    assign rdata     = page[col];
    assign seq_rdata = page[seq_col];

endmodule

`default_nettype wire

// File: design/nand_pkg.sv
// NAND flash model package with geometry, command codes, ID bytes, busy lengths and shared types
`default_nettype none

package nand_pkg;

    // Geometry defaults, the top level may override them
    localparam int COL_BITS   = 4;                      // 16 bytes per page
    localparam int PAGE_BITS  = 2;                      // 4 pages per block
    localparam int BLOCK_BITS = 2;                      // 4 blocks
    localparam int ROW_BITS   = PAGE_BITS + BLOCK_BITS;

    // Busy lengths in clock cycles
    localparam int T_READ  = 40;    // Array to buffer
    localparam int T_PROG  = 120;   // Buffer to array
    localparam int T_ERASE = 200;   // Whole block
    localparam int T_RST   = 10;

    typedef logic [7:0]          io_byte_t;
    typedef logic [COL_BITS-1:0] col_addr_t;    // Byte within page
    typedef logic [ROW_BITS-1:0] row_addr_t;    // Block in upper bits, page in lower

    // Command codes
    localparam io_byte_t CMD_READ1   = 8'h00;
    localparam io_byte_t CMD_READ2   = 8'h30;
    localparam io_byte_t CMD_STATUS  = 8'h70;
    localparam io_byte_t CMD_READ_ID = 8'h90;
    localparam io_byte_t CMD_PROG1   = 8'h80;
    localparam io_byte_t CMD_PROG2   = 8'h10;
    localparam io_byte_t CMD_ERASE1  = 8'h60;
    localparam io_byte_t CMD_ERASE2  = 8'hD0;
    localparam io_byte_t CMD_RESET   = 8'hFF;

    // Maker, device and two extra ID bytes
    localparam io_byte_t ID_BYTES [4] = '{8'hC2, 8'hF1, 8'h80, 8'h1D};

    typedef enum logic [2:0] {
        IDLE,
        READ_ADDR,      // After 00, waiting for 30
        PROG_DATA,      // After 80, address and data until 10
        ERASE_ADDR,     // After 60, row bytes until D0
        BUSY_WAIT       // Sequencer running
    } nand_state_e;

    typedef enum logic [2:0] {
        NONE,
        LOAD,           // Page to buffer
        PROGRAM,        // Buffer into page
        ERASE,          // Block to FF
        RESET
    } seq_op_e;

endpackage

`default_nettype wire

// File: dv/nand_flash_chk.sv
// NAND protocol checker with concurrent assertions, bound into the flash top level
`default_nettype none

module nand_flash_chk (
    input logic RE_B,
    input logic CE_B,
    input logic cle,
    input logic we,
    input logic re,
    input logic dout_valid,
    input logic ryby
);
    timeunit 1ns;
    timeprecision 100ps;

    int fails = 0;      // Assertion failures so far

    // Read data only in the cycle after a read strobe
    valid_after_re: assert property (@(posedge RE_B) disable iff (CE_B)
        dout_valid |-> $past(re))
        else begin
            $error("dout_valid high without a read strobe in the previous cycle");
            fails++;
        end

    // Busy only starts from a command cycle
    busy_from_cmd: assert property (@(posedge RE_B) disable iff (CE_B)
        $fell(ryby) |-> $past(we && cle))
        else begin
            $error("ryby fell without a command in the previous cycle");
            fails++;
        end

    ready_after_reset: assert property (@(posedge RE_B)
        ($past(CE_B) && !CE_B) |-> ryby)
        else begin
            $error("ryby low right after reset");
            fails++;
        end

endmodule

bind nand_flash_top nand_flash_chk i_chk (
    .RE_B(RE_B), .CE_B(CE_B), .cle(cle), .we(we), .re(re),
    .dout_valid(dout_valid), .ryby(ryby)
);

`default_nettype wire

// File: dv/nand_monitor.sv
// NAND read checker, compares each returned byte with the trace and checks the status bits
`default_nettype none

module nand_monitor (
    input  logic               RE_B,
    input  logic               CE_B,
    input  logic               cle,
    input  logic               we,
    input  logic               re,
    input  logic               wp_n,
    input  logic               ryby,
    input  logic               dout_valid,
    input  nand_pkg::io_byte_t din,
    input  nand_pkg::io_byte_t dout,
    input  nand_pkg::io_byte_t exp_byte,
    input  logic               exp_en,
    output int                 val_errs,
    output int                 proto_errs
);
    timeunit 1ns;
    timeprecision 100ps;
    import nand_pkg::*;

    logic     pend;         // Checked read in flight
    logic     stat_mode;    // Host's last taken command was 70
    logic     stat_q;
    logic     ryby_q;       // Ready as seen by the read
    logic     wp_q;
    io_byte_t exp_q;

    always @(posedge RE_B) begin
        if (CE_B) begin
            pend       = 1'b0;
            stat_mode  = 1'b0;
            val_errs   = 0;
            proto_errs = 0;
        end else begin
            if (dout_valid && !pend) begin
                $display("Read data appeared at %0t without a checked read", $time);
                proto_errs++;
            end else if (dout_valid) begin
                if (dout !== exp_q) begin
                    $display("ERR dout expected %h got %h at %0t", exp_q, dout, $time);
                    val_errs++;
                end
                if (stat_q && dout[6] !== ryby_q) begin
                    $display("ERR dout[6] expected %h got %h at %0t", ryby_q, dout[6], $time);
                    val_errs++;
                end
                if (stat_q && dout[7] !== wp_q) begin
                    $display("ERR dout[7] expected %h got %h at %0t", wp_q, dout[7], $time);
                    val_errs++;
                end
            end else if (pend) begin
                $display("No read data returned one cycle after the read at %0t", $time);
                proto_errs++;
            end
            pend = re && exp_en;
            if (pend) begin
                exp_q  = exp_byte;
                stat_q = stat_mode;
                ryby_q = ryby;
                wp_q   = wp_n;
            end
            // Only 70 gets through while busy
            if (we && cle && (ryby || din == CMD_STATUS)) stat_mode = (din == CMD_STATUS);
        end
    end

endmodule

`default_nettype wire

// File: dv/nand_tb.sv
// NAND flash testbench, replays the op trace against the flash model and reports the verdict
`default_nettype none

module nand_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import nand_pkg::*;

    localparam int CLK_HALF = 50;   // 100 ns period

    logic       RE_B;
    logic       CE_B;
    logic       cle;
    logic       ale;
    logic       we;
    logic       re;
    logic       wp_n;
    io_byte_t   din;
    io_byte_t   dout;
    logic       dout_valid;
    logic       ryby;
    io_byte_t   exp_byte;               // Expected byte of the current read
    logic       exp_en;
    int         val_errs;
    int         proto_errs;
    int         setup_errs;
    int         total;
    int         n_ops;
    logic [7:0] ops [$];                // Op letters in trace order
    io_byte_t   args [$];

    nand_flash_top i_dut (
        .RE_B(RE_B), .CE_B(CE_B), .cle(cle), .ale(ale), .we(we), .re(re),
        .wp_n(wp_n), .din(din), .dout(dout), .dout_valid(dout_valid), .ryby(ryby)
    );

    nand_monitor i_mon (
        .RE_B(RE_B), .CE_B(CE_B), .cle(cle), .we(we), .re(re), .wp_n(wp_n),
        .ryby(ryby), .dout_valid(dout_valid), .din(din), .dout(dout),
        .exp_byte(exp_byte), .exp_en(exp_en),
        .val_errs(val_errs), .proto_errs(proto_errs)
    );

    initial begin
        RE_B = 1'b0;
        forever #CLK_HALF RE_B = ~RE_B;
    end

    // Pairs of op letter and hex byte, lines starting with # are skipped
    task automatic load_trace();
        int       fd;
        int       n;
        int       ch;
        io_byte_t val;
        fd = $fopen("dv/nand_trace.txt", "r");
        if (fd == 0) begin
            $display("Trace file dv/nand_trace.txt could not be opened");
            setup_errs++;
        end else begin
            ch = $fgetc(fd);
            while (ch != -1) begin
                if (ch == "#") begin
                    while (ch != 10 && ch != -1) ch = $fgetc(fd);   // Rest of comment line
                end else if (ch > 32) begin
                    n = $fscanf(fd, " %h", val);
                    if (n != 1) begin
                        $display("Trace entry %0d has no hex byte", ops.size());
                        setup_errs++;
                    end
                    ops.push_back(8'(ch));
                    args.push_back(val);
                end
                ch = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // One bus cycle, all inputs change just after the rising edge
    task automatic strobe(input logic c, input logic a, input logic w, input logic r,
                          input io_byte_t d, input logic chk);
        @(posedge RE_B);
        cle      <= c;
        ale      <= a;
        we       <= w;
        re       <= r;
        din      <= d;
        exp_byte <= d;
        exp_en   <= chk;
    endtask

    task automatic wait_ready();
        strobe(1'b0, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0);
        @(negedge RE_B);                          // Busy from the last command visible here
        while (ryby !== 1'b1) @(negedge RE_B);
    endtask

    task automatic run_trace();
        foreach (ops[i]) begin
            case (ops[i])
                "C": strobe(1'b1, 1'b0, 1'b1, 1'b0, args[i], 1'b0);
                "A": strobe(1'b0, 1'b1, 1'b1, 1'b0, args[i], 1'b0);
                "W": strobe(1'b0, 1'b0, 1'b1, 1'b0, args[i], 1'b0);
                "R": strobe(1'b0, 1'b0, 1'b0, 1'b1, args[i], 1'b1);
                "B": wait_ready();
                "P": begin
                    strobe(1'b0, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0);
                    wp_n <= args[i][0];
                end
                default: begin
                    $display("Unknown trace operation %c at entry %0d", ops[i], i);
                    setup_errs++;
                end
            endcase
        end
    endtask

    initial begin
        CE_B       = 1'b1;
        cle        = 1'b0;
        ale        = 1'b0;
        we         = 1'b0;
        re         = 1'b0;
        wp_n       = 1'b1;
        din        = 8'h00;
        exp_byte   = 8'h00;
        exp_en     = 1'b0;
        setup_errs = 0;
        n_ops      = 0;
        load_trace();
        if (ops.size() == 0) begin
            $display("Trace holds no operations");
            setup_errs++;
        end
        n_ops = ops.size();
        repeat (3) @(posedge RE_B);
        CE_B <= 1'b0;
        run_trace();
        strobe(1'b0, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0);
        repeat (3) @(posedge RE_B);                // Last read reaches the monitor
        total = val_errs + proto_errs + i_dut.i_chk.fails + setup_errs;
        $display("Errors: %0d value, %0d protocol, %0d assertion, %0d setup",
                 val_errs, proto_errs, i_dut.i_chk.fails, setup_errs);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Worst case per op is an erase plus some slack
    initial begin
        wait (n_ops > 0);
        #(n_ops * (T_ERASE + 64) * 2 * CLK_HALF);
        $display("Timeout, %0d trace operations did not finish in time", n_ops);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/nand_trace.txt
# Pairs of op letter and hex byte, read in order across lines
# C command, A address, W data, R read with expected byte, B wait for ready, P set wp_n
C 90 A 00 R C2 R F1 R 80 R 1D
C 60 A 04 A 00 C D0 B 00
C 00 A 00 A 00 A 05 A 00 C 30 B 00
R FF R FF R FF R FF R FF R FF R FF R FF R FF R FF R FF R FF R FF R FF R FF R FF
C 80 A 00 A 00 A 04 A 00
W 3C W A5 W 5A W 0F W F0 W 96 W 69 W C3 W 7E W E7 W 81 W 18 W FF W 00 W DB W 24
C 10 B 00
C 00 A 00 A 00 A 04 A 00 C 30 B 00
R 3C R A5 R 5A R 0F R F0 R 96 R 69 R C3 R 7E R E7 R 81 R 18 R FF R 00 R DB R 24
C 80 A 00 A 00 A 04 A 00
W F0 W 0F W 33 W CC W 55 W AA W FF W 00 W 0F W F0 W C3 W 3C W 99 W 66 W 18 W 81
C 10 C 70 R 80 B 00 R E0
C 00 A 00 A 00 A 04 A 00 C 30 B 00
R 30 R 05 R 12 R 0C R 50 R 82 R 69 R 00 R 0E R E0 R 81 R 18 R 99 R 00 R 18 R 00
P 00 C 80 A 00 A 00 A 04 A 00 W 00 W 00 W 00 W 00 C 10
C 60 A 04 A 00 C D0 C 70 R 60
C 00 A 00 A 00 A 04 A 00 C 30 B 00
R 30 R 05 R 12 R 0C R 50 R 82 R 69 R 00 R 0E R E0 R 81 R 18 R 99 R 00 R 18 R 00
P 01 C FF B 00 C 90 A 00 R C2 R F1 R 80 R 1D
C 70 R E0
